// File: tb.f
spec_pkg.sv
spec_layout.sv
spec_grid_gen.sv
spec_bar_render.sv
spec_display_top.sv
spec_display_assertions.sv
tb_spec_display.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the spectrum display testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_spec_display \
    --Mdir obj_dir \
    -o tb_spec_display

# exit status of the simulation is the test result
./obj_dir/tb_spec_display

// File: tb_spec_display.sv
// ----------------------------------------
// spectrum display testbench
// random bar scans checked against a pixel model
// ----------------------------------------
module tb_spec_display import spec_pkg::*; ();

    logic        lcd_pclk;
    logic        rst_n;
    logic [15:0] lcd_id;
    coord_t      h_disp;
    coord_t      v_disp;
    coord_t      pixel_xpos;
    coord_t      pixel_ypos;
    logic [7:0]  fft_point_cnt;
    logic [7:0]  fft_data;
    rgb_t        pixel_data;
    logic        data_req;
    logic        fft_point_done;

    // layout model of the current panel
    int   m_step;
    int   m_xs;
    int   m_xe;
    int   m_ys;
    int   m_ye;
    int   m_sp;     // horizontal line spacing, half rows
    int   m_hd;
    logic m_half;

    logic [7:0]  mags [256];  // bin magnitudes of the fft source
    int          rows [$];
    int          cur_x;
    int          cur_y;
    int          cur_cnt;
    int          cur_data;
    int          prv_x;
    int          prv_y;
    int          prv_cnt;
    int          prv_data;
    bit          prv_valid;
    bit          req_seen;
    bit          done_seen;
    int          done_total;

    spec_display_top dut_i (
        .lcd_pclk       (lcd_pclk),
        .rst_n          (rst_n),
        .lcd_id         (lcd_id),
        .h_disp         (h_disp),
        .v_disp         (v_disp),
        .pixel_xpos     (pixel_xpos),
        .pixel_ypos     (pixel_ypos),
        .fft_point_cnt  (fft_point_cnt),
        .fft_data       (fft_data),
        .pixel_data     (pixel_data),
        .data_req       (data_req),
        .fft_point_done (fft_point_done)
    );

    initial begin
        lcd_pclk = 1'b0;
        forever #4 lcd_pclk = ~lcd_pclk;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic bit on_vline(input int x, input int y);
        bit hit;
        hit = (x == m_xs - 1) || (x == m_xs);  // left edge
        for (int k = 1; k <= GRID_LINES; k++) begin
            if (x == m_xs + k * int'(GRID_BINS) * m_step) begin
                hit = 1'b1;
            end
        end
        return hit && (y >= m_ys) && (y <= m_ye);
    endfunction

    function automatic bit on_hline(input int x, input int y);
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < GRID_LINES; k++) begin
            if (y / 2 == m_ye / 2 - k * m_sp) begin
                hit = 1'b1;
            end
        end
        return hit && (x >= m_xs - 1) && (x <= m_xe - 1);
    endfunction

    function automatic rgb_t pixel_colour(input int x, input int y, input int cnt,
                                          input int data);
        int lo;
        int height;
        lo     = cnt * m_step + int'(H_OFFSET);
        height = m_half ? data : 2 * data;
        if (on_vline(x, y) || on_hline(x, y)) begin
            return COLOR_RED;
        end
        if ((x >= lo) && (x < lo + m_step) && (height != 0) &&
            (y >= m_ye - height) && (y <= m_ye)) begin
            return COLOR_BLUE;
        end
        return COLOR_WHITE;
    endfunction

    function automatic bit expect_req(input int x, input int y, input int cnt);
        return (x == (cnt + 1) * m_step - int'(REQ_LEAD) + int'(H_OFFSET)) && (y >= m_ys);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %0h expected %0h at x %0d y %0d",
                     name, got, exp, prv_x, prv_y);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // one pixel, fft source answers last strobes
    // ----------------------------------------
    task automatic step_pixel(input int x, input int y);
        int next_cnt;
        next_cnt = cur_cnt;
        if (done_seen) begin
            next_cnt = 0;               // line done restarts the bins
        end else if (req_seen) begin
            next_cnt = cur_cnt + 1;
        end
        @(posedge lcd_pclk);
        pixel_xpos    <= coord_t'(x);
        pixel_ypos    <= coord_t'(y);
        fft_point_cnt <= 8'(next_cnt);
        fft_data      <= mags[8'(next_cnt)];
        prv_x    = cur_x;
        prv_y    = cur_y;
        prv_cnt  = cur_cnt;
        prv_data = cur_data;
        cur_x    = x;
        cur_y    = y;
        cur_cnt  = next_cnt;
        cur_data = int'(mags[8'(next_cnt)]);
        @(negedge lcd_pclk);
        if (prv_valid) begin
            check_value("pixel_data", 32'(pixel_data),
                        32'(pixel_colour(prv_x, prv_y, prv_cnt, prv_data)));
            check_value("data_req", 32'(data_req), 32'(expect_req(prv_x, prv_y, prv_cnt)));
            check_value("fft_point_done", 32'(fft_point_done), 32'(prv_x == m_hd - 1));
        end
        req_seen  = data_req;
        done_seen = fft_point_done;
        if (fft_point_done) begin
            done_total++;
        end
        prv_valid = 1'b1;
    endtask

    task automatic run_panel(input logic [15:0] id, input int hd, input int vd);
        int base;
        @(posedge lcd_pclk);
        lcd_id        <= id;
        h_disp        <= coord_t'(hd);
        v_disp        <= coord_t'(vd);
        pixel_xpos    <= '0;
        pixel_ypos    <= '0;
        fft_point_cnt <= '0;
        fft_data      <= '0;
        m_step = (hd / 128 - 1) & 15;
        m_xs   = int'(H_OFFSET);
        m_xe   = m_xs + m_step * int'(FFT_POINTS);
        m_ye   = vd - int'(V_OFFSET);
        m_sp   = (id[7:0] == SMALL_PANEL_ID) ? int'(HGRID_SMALL) : int'(HGRID_LARGE);
        m_ys   = m_ye - ((id[7:0] == SMALL_PANEL_ID) ? int'(SPAN_SMALL) : int'(SPAN_LARGE));
        m_half = id[2];
        m_hd   = hd;
        for (int i = 0; i < 256; i++) begin
            mags[8'(i)] = ($urandom % 4 == 0) ? 8'd0 : 8'($urandom % 256);  // some empty bins
        end
        repeat (4) @(posedge lcd_pclk);  // settings settle
        cur_x = 0;
        cur_y = 0;
        cur_cnt = 0;
        cur_data = 0;
        prv_valid = 1'b0;
        req_seen = 1'b0;
        done_seen = 1'b0;
        done_total = 0;
        // rows around frame top, every level line and two random rows
        rows = {};
        rows.push_back(0);
        rows.push_back(m_ys - 1);
        rows.push_back(m_ys);
        for (int k = 0; k < GRID_LINES; k++) begin
            base = m_ye - 2 * k * m_sp;
            rows.push_back(base - 1);
            rows.push_back(base);
            rows.push_back(base + 1);
        end
        rows.push_back(m_ys + int'($urandom % 200));
        rows.push_back(m_ys + int'($urandom % 200));
        foreach (rows[i]) begin
            for (int x = 0; x < hd; x++) begin
                step_pixel(x, rows[i]);
            end
        end
        step_pixel(0, 0);  // flush last pixel
        check_value("fft_point_done count", 32'(done_total), 32'(rows.size()));
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(98055));
        rst_n         = 1'b0;
        lcd_id        = 16'h0084;
        h_disp        = 11'd800;
        v_disp        = 11'd480;
        pixel_xpos    = '0;
        pixel_ypos    = '0;
        fft_point_cnt = '0;
        fft_data      = '0;
        prv_x         = 0;
        prv_y         = 0;
        repeat (2) @(posedge lcd_pclk);
        @(negedge lcd_pclk);
        check_value("pixel_data", 32'(pixel_data), 32'(COLOR_WHITE));
        check_value("data_req", 32'(data_req), 32'd0);
        check_value("fft_point_done", 32'(fft_point_done), 32'd0);
        @(posedge lcd_pclk);
        rst_n <= 1'b1;
        @(negedge lcd_pclk);
        check_value("pixel_data", 32'(pixel_data), 32'(COLOR_WHITE));
        check_value("data_req", 32'(data_req), 32'd0);
        check_value("fft_point_done", 32'(fft_point_done), 32'd0);

        run_panel(16'h0084, 800, 480);   // small panel, raw magnitude
        run_panel(16'h1018, 800, 600);   // large panel, doubled magnitude
        run_panel(16'h1018, 1024, 600);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: spec_display_assertions.sv
// ----------------------------------------
// spectrum display assertions
// strobe width, colour set and reset state
// ----------------------------------------
module spec_display_assertions import spec_pkg::*; (
    input logic lcd_pclk,
    input logic rst_n,
    input rgb_t pixel_data,
    input logic data_req,
    input logic fft_point_done
);

    logic in_reset;  // reset seen by the last clock edge

    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            in_reset <= 1'b1;
        end else begin
            in_reset <= 1'b0;
        end
    end

    // ----------------------------------------
    // strobes are single cycle
    // ----------------------------------------
    req_pulse_a: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        data_req |=> !data_req)
        else $error("data_req high for two cycles");

    done_pulse_a: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        fft_point_done |=> !fft_point_done)
        else $error("fft_point_done high for two cycles");

    // only the three palette colours
    colour_set_a: assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        (pixel_data == COLOR_WHITE) || (pixel_data == COLOR_RED) ||
        (pixel_data == COLOR_BLUE))
        else $error("pixel_data %h outside the palette", pixel_data);

    reset_state_a: assert property (@(posedge lcd_pclk) (!rst_n && in_reset) |->
        (pixel_data == COLOR_WHITE) && !data_req && !fft_point_done)
        else $error("outputs active during reset");

endmodule

bind spec_display_top spec_display_assertions assertions_i (
    .lcd_pclk       (lcd_pclk),
    .rst_n          (rst_n),
    .pixel_data     (pixel_data),
    .data_req       (data_req),
    .fft_point_done (fft_point_done)
);

// File: spec_display_top.sv
// ----------------------------------------
// lcd spectrum display top
// layout, grid and bar renderer
// ----------------------------------------
module spec_display_top import spec_pkg::*; (
    input  logic        lcd_pclk,
    input  logic        rst_n,
    input  logic [15:0] lcd_id,
    input  coord_t      h_disp,
    input  coord_t      v_disp,
    input  coord_t      pixel_xpos,
    input  coord_t      pixel_ypos,
    input  logic [7:0]  fft_point_cnt,  // bin index from fft source
    input  logic [7:0]  fft_data,       // bin magnitude
    output rgb_t        pixel_data,
    output logic        data_req,
    output logic        fft_point_done
);

    disp_cfg_t  cfg;
    pixel_pos_t pos;
    layout_t    layout;
    grid_hit_t  grid;

    assign cfg = '{h_disp: h_disp, v_disp: v_disp, lcd_id: lcd_id};
    assign pos = '{x: pixel_xpos, y: pixel_ypos};

    // ----------------------------------------
    // blocks
    // ----------------------------------------
    spec_layout layout_i (
        .lcd_pclk (lcd_pclk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .layout   (layout)
    );

    spec_grid_gen grid_i (
        .pos    (pos),
        .layout (layout),
        .grid   (grid)
    );

    spec_bar_render render_i (
        .lcd_pclk       (lcd_pclk),
        .rst_n          (rst_n),
        .pos            (pos),
        .layout         (layout),
        .grid           (grid),
        .h_disp         (cfg.h_disp),
        .half_scale     (cfg.lcd_id[2]),   // 1 px per magnitude step
        .fft_point_cnt  (fft_point_cnt),
        .fft_data       (fft_data),
        .pixel_data     (pixel_data),
        .data_req       (data_req),
        .fft_point_done (fft_point_done)
    );

endmodule

// File: spec_bar_render.sv
// ----------------------------------------
// spectrum bar renderer
// fft request strobes and final pixel colour
// ----------------------------------------
module spec_bar_render import spec_pkg::*; (
    input  logic       lcd_pclk,
    input  logic       rst_n,
    input  pixel_pos_t pos,
    input  layout_t    layout,
    input  grid_hit_t  grid,
    input  coord_t     h_disp,
    input  logic       half_scale,     // lcd_id bit 2
    input  logic [7:0] fft_point_cnt,
    input  logic [7:0] fft_data,
    output rgb_t       pixel_data,
    output logic       data_req,
    output logic       fft_point_done
);

    // ----------------------------------------
    // current bar window
    // ----------------------------------------
    coord_t     bar_lo;      // first pixel of the bar
    coord_t     bar_hi;      // first pixel past the bar
    coord_t     req_x;       // request position
    logic       in_bar_x;

    assign bar_lo = coord_t'(fft_point_cnt) * coord_t'(layout.step) + H_OFFSET;
    assign bar_hi = bar_lo + coord_t'(layout.step);
    assign req_x  = bar_hi - REQ_LEAD;

    assign in_bar_x = (pos.x >= bar_lo) && (pos.x < bar_hi);

    // ----------------------------------------
    // bar height
    // ----------------------------------------
    logic [8:0] bar_height;
    coord_t     bar_top;
    logic       in_bar_y;
    logic       in_bar;

    // small panels show the raw magnitude, others twice it
    assign bar_height = half_scale ? {1'b0, fft_data} : {fft_data, 1'b0};
    assign bar_top    = layout.y_end - coord_t'(bar_height);

    assign in_bar_y = (bar_height != 9'd0) &&
                      (pos.y >= bar_top) && (pos.y <= layout.y_end);

    assign in_bar = in_bar_x && in_bar_y;

    // ----------------------------------------
    // fft source strobes
    // ----------------------------------------
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            data_req       <= 1'b0;
            fft_point_done <= 1'b0;
        end else begin
            // ask for the next bin a few pixels before this bar ends
            data_req       <= (pos.x == req_x) && (pos.y >= layout.y_start);
            fft_point_done <= (pos.x == h_disp - 11'd1);  // end of line
        end
    end

    // ----------------------------------------
    // pixel colour
    // ----------------------------------------
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_data <= COLOR_WHITE;
        end else begin
            if (grid.vline) begin
                pixel_data <= COLOR_RED;
            end else if (grid.hline) begin
                pixel_data <= COLOR_RED;
            end else if (in_bar) begin
                pixel_data <= COLOR_BLUE;
            end else begin
                pixel_data <= COLOR_WHITE;  // background
            end
        end
    end

endmodule

// File: spec_grid_gen.sv
// ----------------------------------------
// frame and grid line detector
// flags pixels on red vertical or horizontal lines
// ----------------------------------------
module spec_grid_gen import spec_pkg::*; (
    input  pixel_pos_t pos,
    input  layout_t    layout,
    output grid_hit_t  grid
);

    // ----------------------------------------
    // vertical lines
    // ----------------------------------------
    logic   in_yspan;     // between frame top and base
    logic   on_left_edge;
    logic   on_vtap;
    coord_t vgrid_pitch;  // pixels between vertical lines

    assign in_yspan = (pos.y >= layout.y_start) && (pos.y <= layout.y_end);

    // two pixel wide left edge
    assign on_left_edge = (pos.x == layout.x_start - 11'd1) ||
                          (pos.x == layout.x_start);

    assign vgrid_pitch = GRID_BINS * coord_t'(layout.step);

    // one line every GRID_BINS bars, the last one is the right edge
    always_comb begin
        on_vtap = 1'b0;
        for (int k = 1; k <= GRID_LINES; k++) begin
            if (pos.x == layout.x_start + coord_t'(k) * vgrid_pitch) begin
                on_vtap = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // horizontal lines
    // ----------------------------------------
    logic       in_xspan;
    logic [9:0] half_row;      // y in half rows
    logic [9:0] half_base;
    logic [9:0] hgrid_pitch;
    logic       on_htap;

    assign in_xspan = (pos.x >= layout.x_start - 11'd1) &&
                      (pos.x <= layout.x_end - 11'd1);

    // lines are two rows thick, compare on y/2
    assign half_row  = pos.y[10:1];
    assign half_base = layout.y_end[10:1];

    assign hgrid_pitch = layout.small_panel ? HGRID_SMALL : HGRID_LARGE;

    // base line plus the level lines above it
    always_comb begin
        on_htap = 1'b0;
        for (int k = 0; k < GRID_LINES; k++) begin
            if (half_row == half_base - 10'(k) * hgrid_pitch) begin
                on_htap = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // result
    // ----------------------------------------
    always_comb begin
        grid.vline = in_yspan && (on_left_edge || on_vtap);
        grid.hline = in_xspan && on_htap;
    end

endmodule

// File: spec_layout.sv
// ----------------------------------------
// spectrum layout registers
// frame corners and bar step from panel size and id
// ----------------------------------------
module spec_layout import spec_pkg::*; (
    input  logic      lcd_pclk,
    input  logic      rst_n,
    input  disp_cfg_t cfg,
    output layout_t   layout
);

    logic [3:0] step_nxt;
    coord_t     x_end_nxt;
    coord_t     y_end_nxt;
    coord_t     span;
    logic       small_nxt;

    // 128 px per step unit, one less to leave room for the frame
    assign step_nxt  = cfg.h_disp[10:7] - 4'd1;
    assign x_end_nxt = H_OFFSET + coord_t'(step_nxt) * FFT_POINTS;

    assign small_nxt = (cfg.lcd_id[7:0] == SMALL_PANEL_ID);
    assign span      = small_nxt ? SPAN_SMALL : SPAN_LARGE;

    assign y_end_nxt = cfg.v_disp - V_OFFSET;  // base line

    // ----------------------------------------
    // geometry register
    // ----------------------------------------
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            layout <= '0;
        end else begin
            layout.step        <= step_nxt;
            layout.x_start     <= H_OFFSET;
            layout.x_end       <= x_end_nxt;
            layout.y_start     <= y_end_nxt - span;  // top of frame
            layout.y_end       <= y_end_nxt;
            layout.small_panel <= small_nxt;
        end
    end

endmodule

// File: spec_pkg.sv
// ----------------------------------------
// spectrum display shared package
// pixel types, colours and layout constants
// ----------------------------------------
package spec_pkg;

    // ----------------------------------------
    // basic types
    // ----------------------------------------
    typedef logic [10:0] coord_t;    // screen coordinate
    typedef logic [23:0] rgb_t;      // rgb888 colour

    // current pixel from the lcd timing
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    // panel settings
    typedef struct packed {
        coord_t      h_disp;
        coord_t      v_disp;
        logic [15:0] lcd_id;
    } disp_cfg_t;

    // registered frame and bar geometry
    typedef struct packed {
        logic [3:0] step;         // bar width in pixels
        coord_t     x_start;
        coord_t     x_end;
        coord_t     y_start;      // top of frame
        coord_t     y_end;        // base line
        logic       small_panel;  // 800x480 class panel
    } layout_t;

    // which red feature covers the pixel
    typedef struct packed {
        logic vline;
        logic hline;
    } grid_hit_t;

    // ----------------------------------------
    // colours
    // ----------------------------------------
    localparam rgb_t COLOR_WHITE = 24'hff_ff_ff;
    localparam rgb_t COLOR_RED   = 24'hff_00_00;
    localparam rgb_t COLOR_BLUE  = 24'h00_00_ff;

    // ----------------------------------------
    // layout constants
    // ----------------------------------------
    localparam coord_t H_OFFSET   = 11'd64;   // left margin
    localparam coord_t V_OFFSET   = 11'd44;   // bottom margin
    localparam coord_t FFT_POINTS = 11'd120;  // bars on screen
    localparam coord_t GRID_BINS  = 11'd20;   // bars per vertical grid cell
    localparam int     GRID_LINES = 6;

    // horizontal spacing counted in half rows
    localparam logic [9:0] HGRID_SMALL = 10'd25;
    localparam logic [9:0] HGRID_LARGE = 10'd50;

    localparam coord_t SPAN_SMALL = 11'd250;  // frame height, small panel
    localparam coord_t SPAN_LARGE = 11'd500;

    localparam logic [7:0] SMALL_PANEL_ID = 8'h84;
    localparam coord_t     REQ_LEAD       = 11'd3;  // request lead before bar end

endpackage
